/* source/rv32_settings.svh */
// ---------------------------------------------------------------------
// Core-wide constants for the two-stage RV32I core. Include this file
// in any RTL or testbench file that needs the reset vector or the
// padding word for squashed slots.
// ---------------------------------------------------------------------
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// first address fetched once rst drops
`define RV_RESET_PC 32'h0000_0100

// ADDI x0, x0, 0 is the canonical RV32I no-op
`define RV_NOP 32'h0000_0013

`endif

/* source/rv32_pkg.sv */
// ---------------------------------------------------------------------
// Shared types for the RV32I core: data word, register index, major
// opcodes, ALU operations and the operand and write-back selects.
// Files reference these through rv32_pkg:: scoped names.
// ---------------------------------------------------------------------
package rv32_pkg;

  typedef logic [31:0] word_t;     // data or address word
  typedef logic [4:0]  reg_idx_t;  // index into the 32-entry register file

  // major opcodes in instr[6:0], the only ones this core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // register-register ALU ops
    OPC_OP_IMM = 7'b0010011,  // register-immediate ALU ops
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [1:0] {
    A_RS1,   // register operand
    A_PC,    // auipc adds to the instruction address
    A_ZERO   // idle value when the ALU result is not written
  } alu_a_sel_t;

  typedef enum logic [1:0] {
    B_RS2,    // register-register form
    B_IMM_I,  // sign-extended 12-bit immediate
    B_SHAMT,  // zero-extended shift amount for slli/srli/srai
    B_IMM_U   // upper immediate for auipc
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    W_ALU,    // ALU result
    W_NPC,    // link address pc+4 for jal/jalr
    W_IMM_U   // lui writes the immediate straight through
  } w_sel_t;

endpackage

/* source/fetch_stage.sv */
// ---------------------------------------------------------------------
// Fetch half of the two-stage pipe. Presents the fetch PC to an
// external memory with one cycle of read latency and hands the word,
// its address and a valid bit to execute. A redirect squashes one slot.
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "rv32_settings.svh"

module fetch_stage (
  input  logic            CLK,
  input  logic            rst,
  input  logic            redirect,    // one-cycle pulse from execute
  input  rv32_pkg::word_t target,      // jump destination, valid with redirect
  input  rv32_pkg::word_t imem_data,   // word for the address sent last cycle
  output rv32_pkg::word_t imem_addr,
  output rv32_pkg::word_t instr,
  output rv32_pkg::word_t pc,
  output logic            instr_valid
);

  rv32_pkg::word_t fetch_pc;    // address leaving on imem_addr this cycle
  rv32_pkg::word_t data_pc;     // address of the word now arriving on imem_data
  logic            data_valid;  // low for the reset slot and after a redirect

  always_ff @(posedge CLK) begin
    if (rst) begin
      fetch_pc   <= `RV_RESET_PC;
      data_valid <= 1'b0;
    end else begin
      fetch_pc   <= redirect ? target : fetch_pc + 32'd4;  // no stalls ever
      data_valid <= ~redirect;  // the word already requested is on the wrong path
    end
  end

  always_ff @(posedge CLK) data_pc <= fetch_pc;  // follows the memory latency

  assign imem_addr   = fetch_pc;
  assign pc          = data_pc;
  assign instr_valid = data_valid;
  assign instr       = data_valid ? imem_data : `RV_NOP;  // squashed slot becomes a nop
endmodule

/* source/control_unit.sv */
// ---------------------------------------------------------------------
// Instruction decoder for the execute stage. Splits the word into
// register fields and raw immediates and derives the ALU operation,
// operand selects, write-back select and jump controls.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module control_unit (
  input  rv32_pkg::word_t      instr,
  output rv32_pkg::reg_idx_t   rs1,
  output rv32_pkg::reg_idx_t   rs2,
  output rv32_pkg::reg_idx_t   rd,
  output logic [11:0]          imm_i,
  output logic [20:0]          imm_j,      // bit 0 is always zero
  output rv32_pkg::word_t      imm_u,
  output logic [4:0]           shamt,
  output rv32_pkg::alu_op_t    alu_op,
  output rv32_pkg::alu_a_sel_t alu_a_sel,
  output rv32_pkg::alu_b_sel_t alu_b_sel,
  output rv32_pkg::w_sel_t     w_sel,
  output logic                 reg_wen,
  output logic                 is_jump,
  output logic                 j_sel       // 1 for jal (pc based), 0 for jalr
);

  logic [2:0] funct3;
  logic       alt;  // instr[30] picks sub and sra

  assign funct3 = instr[14:12];
  assign alt    = instr[30];

  assign rs1   = instr[19:15];
  assign rs2   = instr[24:20];
  assign rd    = instr[11:7];
  assign imm_i = instr[31:20];
  assign imm_j = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign shamt = instr[24:20];  // same bits as rs2, only meaningful for shifts

  always_comb begin
    alu_op    = rv32_pkg::ALU_ADD;  // defaults describe an instruction that writes nothing
    alu_a_sel = rv32_pkg::A_ZERO;
    alu_b_sel = rv32_pkg::B_RS2;
    w_sel     = rv32_pkg::W_ALU;
    reg_wen   = 1'b0;
    is_jump   = 1'b0;
    j_sel     = 1'b0;
    case (rv32_pkg::opcode_t'(instr[6:0]))
      rv32_pkg::OPC_OP, rv32_pkg::OPC_OP_IMM: begin
        reg_wen   = 1'b1;
        alu_a_sel = rv32_pkg::A_RS1;
        if (instr[6:0] == rv32_pkg::OPC_OP)
          alu_b_sel = rv32_pkg::B_RS2;
        else if (funct3[1:0] == 2'b01)
          alu_b_sel = rv32_pkg::B_SHAMT;  // slli/srli/srai keep funct7 out of the operand
        else
          alu_b_sel = rv32_pkg::B_IMM_I;
        case (funct3)
          3'b000: begin
            // only the register form has a subtract
            alu_op = (alu_b_sel == rv32_pkg::B_RS2 && alt) ? rv32_pkg::ALU_SUB
                                                          : rv32_pkg::ALU_ADD;
          end
          3'b001: alu_op = rv32_pkg::ALU_SLL;
          3'b010: alu_op = rv32_pkg::ALU_SLT;
          3'b011: alu_op = rv32_pkg::ALU_SLTU;
          3'b100: alu_op = rv32_pkg::ALU_XOR;
          3'b101: alu_op = alt ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
          3'b110: alu_op = rv32_pkg::ALU_OR;
          default: alu_op = rv32_pkg::ALU_AND;
        endcase
      end
      rv32_pkg::OPC_LUI: begin
        reg_wen = 1'b1;
        w_sel   = rv32_pkg::W_IMM_U;  // bypasses the ALU entirely
      end
      rv32_pkg::OPC_AUIPC: begin
        reg_wen   = 1'b1;
        alu_a_sel = rv32_pkg::A_PC;
        alu_b_sel = rv32_pkg::B_IMM_U;
      end
      rv32_pkg::OPC_JAL: begin
        reg_wen = 1'b1;
        w_sel   = rv32_pkg::W_NPC;
        is_jump = 1'b1;
        j_sel   = 1'b1;
      end
      rv32_pkg::OPC_JALR: begin
        reg_wen = 1'b1;
        w_sel   = rv32_pkg::W_NPC;
        is_jump = 1'b1;
      end
      default: ;  // loads, stores, branches and the rest retire without a write
    endcase
  end
endmodule

/* source/reg_file.sv */
// ---------------------------------------------------------------------
// 32 x 32 integer register file with two combinational read ports and
// one write port that lands on the clock edge. x0 reads as zero and
// ignores writes.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module reg_file (
  input  logic               CLK,
  input  logic               rst,
  input  rv32_pkg::reg_idx_t rs1,
  input  rv32_pkg::reg_idx_t rs2,
  input  rv32_pkg::reg_idx_t rd,
  input  logic               wen,
  input  rv32_pkg::word_t    w_data,
  output rv32_pkg::word_t    rs1_data,
  output rv32_pkg::word_t    rs2_data
);

  rv32_pkg::word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;  // architectural state starts at zero
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= w_data;
    end
  end

  // reads see the value before this cycle's write since nothing follows execute
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];
endmodule

/* source/alu.sv */
// ---------------------------------------------------------------------
// Integer ALU covering the ten RV32I arithmetic, logic, compare and
// shift operations. Purely combinational and used by the execute stage
// for both register and immediate forms.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module alu (
  input  rv32_pkg::alu_op_t alu_op,
  input  rv32_pkg::word_t   port_a,
  input  rv32_pkg::word_t   port_b,
  output rv32_pkg::word_t   port_out
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = port_b[4:0];  // upper bits of port_b never affect a shift
  assign lt_signed   = $signed(port_a) < $signed(port_b);
  assign lt_unsigned = port_a < port_b;

  always_comb begin
    case (alu_op)
      rv32_pkg::ALU_ADD:  port_out = port_a + port_b;  // carry out is dropped
      rv32_pkg::ALU_SUB:  port_out = port_a - port_b;
      rv32_pkg::ALU_SLL:  port_out = port_a << shamt;
      rv32_pkg::ALU_SLT:  port_out = {31'd0, lt_signed};
      rv32_pkg::ALU_SLTU: port_out = {31'd0, lt_unsigned};
      rv32_pkg::ALU_XOR:  port_out = port_a ^ port_b;
      rv32_pkg::ALU_SRL:  port_out = port_a >> shamt;  // zero fill
      rv32_pkg::ALU_SRA:  port_out = $signed(port_a) >>> shamt;  // sign fill
      rv32_pkg::ALU_OR:   port_out = port_a | port_b;
      rv32_pkg::ALU_AND:  port_out = port_a & port_b;
      default:            port_out = '0;  // encodings 10 to 15 are unused
    endcase
  end
endmodule

/* source/execute_stage.sv */
// ---------------------------------------------------------------------
// Execute half of the two-stage pipe. Decodes, reads registers, runs
// the ALU, computes jump targets and writes back in one cycle, then
// reports each retired instruction on the retire trace.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module execute_stage (
  input  logic               CLK,
  input  logic               rst,
  input  rv32_pkg::word_t    instr,
  input  rv32_pkg::word_t    pc,
  input  logic               instr_valid,
  output logic               redirect,
  output rv32_pkg::word_t    target,
  output logic               retire_valid,
  output logic               retire_wen,
  output rv32_pkg::word_t    retire_pc,
  output rv32_pkg::word_t    retire_data,
  output rv32_pkg::reg_idx_t retire_rd
);

  rv32_pkg::reg_idx_t   rs1, rs2, rd;
  logic [11:0]          imm_i;
  logic [20:0]          imm_j;
  rv32_pkg::word_t      imm_u, imm_i_ext, imm_j_ext;
  logic [4:0]           shamt;
  rv32_pkg::alu_op_t    alu_op;
  rv32_pkg::alu_a_sel_t alu_a_sel;
  rv32_pkg::alu_b_sel_t alu_b_sel;
  rv32_pkg::w_sel_t     w_sel;
  logic                 reg_wen, is_jump, j_sel, wen;
  rv32_pkg::word_t      rs1_data, rs2_data, port_a, port_b, alu_out, npc, w_data;

  control_unit cu (.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm_i(imm_i),
                   .imm_j(imm_j), .imm_u(imm_u), .shamt(shamt), .alu_op(alu_op),
                   .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel), .w_sel(w_sel),
                   .reg_wen(reg_wen), .is_jump(is_jump), .j_sel(j_sel));

  reg_file rf (.CLK(CLK), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .wen(wen),
               .w_data(w_data), .rs1_data(rs1_data), .rs2_data(rs2_data));

  alu alu_inst (.alu_op(alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

  assign imm_i_ext = {{20{imm_i[11]}}, imm_i};
  assign imm_j_ext = {{11{imm_j[20]}}, imm_j};  // covers +/- 1 MiB
  assign npc       = pc + 32'd4;  // link value for jal and jalr

  always_comb begin
    case (alu_a_sel)
      rv32_pkg::A_RS1: port_a = rs1_data;
      rv32_pkg::A_PC:  port_a = pc;
      default:         port_a = '0;  // A_ZERO
    endcase
    case (alu_b_sel)
      rv32_pkg::B_RS2:   port_b = rs2_data;
      rv32_pkg::B_IMM_I: port_b = imm_i_ext;
      rv32_pkg::B_SHAMT: port_b = {27'd0, shamt};
      default:           port_b = imm_u;  // B_IMM_U
    endcase
    case (w_sel)
      rv32_pkg::W_NPC:   w_data = npc;
      rv32_pkg::W_IMM_U: w_data = imm_u;
      default:           w_data = alu_out;
    endcase
  end

  // jal is pc relative while jalr adds to rs1 and clears the low bit
  assign target   = j_sel ? pc + imm_j_ext : (rs1_data + imm_i_ext) & ~32'd1;
  assign redirect = instr_valid & is_jump;  // a squashed nop must never jump

  assign wen = instr_valid & reg_wen & (rd != 5'd0);  // x0 writes retire as no write

  assign retire_valid = instr_valid;
  assign retire_wen   = wen;
  assign retire_pc    = pc;
  assign retire_rd    = rd;
  assign retire_data  = w_data;  // the value landing in rd at the next edge
endmodule

/* source/rv32_core.sv */
// ---------------------------------------------------------------------
// Top of the two-stage RV32I core. Joins fetch and execute and exposes
// the instruction memory port and the retire trace. Instruction memory
// lives outside and answers one cycle after each address.
// ---------------------------------------------------------------------
`timescale 1ns/10ps

module rv32_core (
  input  logic               CLK,
  input  logic               rst,
  output rv32_pkg::word_t    imem_addr,
  input  rv32_pkg::word_t    imem_data,     // read data for last cycle's imem_addr
  output logic               retire_valid,
  output logic               retire_wen,
  output rv32_pkg::word_t    retire_pc,
  output rv32_pkg::word_t    retire_data,
  output rv32_pkg::reg_idx_t retire_rd
);

  logic            redirect;     // execute took a jump this cycle
  rv32_pkg::word_t target;
  rv32_pkg::word_t instr;        // word currently in execute
  rv32_pkg::word_t pc;           // its address
  logic            instr_valid;

  fetch_stage fetch_stage_inst (
    .CLK         (CLK),
    .rst         (rst),
    .redirect    (redirect),
    .target      (target),
    .imem_data   (imem_data),
    .imem_addr   (imem_addr),
    .instr       (instr),
    .pc          (pc),
    .instr_valid (instr_valid)
  );

  execute_stage execute_stage_inst (
    .CLK          (CLK),
    .rst          (rst),
    .instr        (instr),
    .pc           (pc),
    .instr_valid  (instr_valid),
    .redirect     (redirect),
    .target       (target),
    .retire_valid (retire_valid),
    .retire_wen   (retire_wen),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data),
    .retire_rd    (retire_rd)
  );

endmodule

/* tests/rv32_core_sva.sv */
// ----------------------------------------------------------------------
// Concurrent assertions on the retire trace of the RV32I core, bound
// into every rv32_core instance. The testbench reads fail_count at the
// end of the run.
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module rv32_core_sva (
  input logic        CLK,
  input logic        rst,
  input logic        retire_valid,
  input logic        retire_wen,
  input logic [31:0] retire_pc,
  input logic [4:0]  retire_rd
);

  int fail_count = 0;  // assertion failures seen so far

  // the x before the first reset edge counts as quiet
  property quiet_in_reset;
    @(posedge CLK) rst |-> (retire_valid !== 1'b1);
  endproperty

  property pc_word_aligned;
    @(posedge CLK) disable iff (rst) retire_valid |-> (retire_pc[1:0] == 2'b00);
  endproperty

  property no_write_to_x0;
    @(posedge CLK) disable iff (rst) retire_wen |-> (retire_rd != 5'd0);
  endproperty

  a_quiet_in_reset: assert property (quiet_in_reset)
    else begin
      $error("instruction retired while reset was high");
      fail_count++;
    end
  a_pc_word_aligned: assert property (pc_word_aligned)
    else begin
      $error("retire pc %h is not word aligned", retire_pc);
      fail_count++;
    end
  a_no_write_to_x0: assert property (no_write_to_x0)
    else begin
      $error("register write reported for x0");
      fail_count++;
    end
endmodule

bind rv32_core rv32_core_sva rv32_core_sva_inst (
  .CLK          (CLK),
  .rst          (rst),
  .retire_valid (retire_valid),
  .retire_wen   (retire_wen),
  .retire_pc    (retire_pc),
  .retire_rd    (retire_rd)
);

/* tests/rv32_checker.sv */
// ----------------------------------------------------------------------
// Retire trace checker. Walks the expected table in order, compares
// every retire against the next entry that must retire, and prints
// one line per test. The testbench reads the counts and done flag.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "rv32_settings.svh"

module rv32_checker #(
  parameter int N = 32
) (
  input  logic        CLK,
  input  logic        rst,
  input  logic        retire_valid,
  input  logic        retire_wen,
  input  logic [31:0] retire_pc,
  input  logic [31:0] retire_data,
  input  logic [4:0]  retire_rd,
  input  logic [79:0] name_tab [N],     // test names as packed ascii
  input  logic        must_retire [N],  // low for slots a jump skips
  input  logic        exp_wen [N],
  input  logic [4:0]  exp_rd [N],
  input  logic [31:0] exp_data [N],
  output int          errors,
  output int          checked,
  output logic        done
);

  int idx = 0;        // next table entry expected to retire
  int err_count = 0;
  int chk_count = 0;

  assign errors  = err_count;
  assign checked = chk_count;
  assign done    = (idx >= N);  // every retiring entry has been seen

  function automatic int next_retiring(input int from);
    int k;
    k = from;
    while (k < N && !must_retire[k]) k++;  // squashed entries never show up
    return k;
  endfunction

  task automatic check_retire(input int i);
    logic [31:0] exp_pc;
    exp_pc = `RV_RESET_PC + 32'(4 * i);  // entries sit word by word from the reset pc
    // rd and data only mean something when the write happens
    if (retire_pc !== exp_pc) begin
      $display("ERROR %s pc expected %h actual %h", name_tab[i], exp_pc, retire_pc);
      err_count++;
    end else if (retire_wen !== exp_wen[i]) begin
      $display("ERROR %s wen expected %b actual %b", name_tab[i], exp_wen[i], retire_wen);
      err_count++;
    end else if (exp_wen[i] && retire_rd !== exp_rd[i]) begin
      $display("ERROR %s rd expected %0d actual %0d", name_tab[i], exp_rd[i], retire_rd);
      err_count++;
    end else if (exp_wen[i] && retire_data !== exp_data[i]) begin
      $display("ERROR %s data expected %h actual %h", name_tab[i], exp_data[i], retire_data);
      err_count++;
    end else begin
      $display("ok    %s", name_tab[i]);
    end
    chk_count++;
  endtask

  always @(posedge CLK) begin
    if (rst) begin
      if (retire_valid === 1'b1) begin
        $display("an instruction retired while reset was high, pc %h", retire_pc);
        err_count++;
      end
      idx = next_retiring(0);
    end else if (retire_valid === 1'b1 && !done) begin
      check_retire(idx);
      idx = next_retiring(idx + 1);
    end
  end
endmodule

/* tests/rv32_core_tb.sv */
// ----------------------------------------------------------------------
// Top testbench for the two-stage RV32I core. Builds a program table
// with expected results, serves it from an instruction memory model
// with one cycle of latency and hands the retire trace to the checker.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`include "rv32_settings.svh"

module rv32_core_tb;

  localparam int N         = 32;
  localparam int TIMEOUT   = 16 + 2 * N + 20;  // reset plus two cycles per entry plus slack
  localparam int MEM_WORDS = 256;              // covers 0x000 to 0x3ff

  logic        CLK = 1'b0;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        retire_valid, retire_wen;
  logic [31:0] retire_pc, retire_data;
  logic [4:0]  retire_rd;

  logic [79:0] name_tab [N];
  logic [31:0] instr_tab [N];
  logic        must_retire [N];
  logic        exp_wen [N];
  logic [4:0]  exp_rd [N];
  logic [31:0] exp_data [N];
  logic [31:0] imem [MEM_WORDS];
  int          n_entries = 0;
  int          cycles = 0;
  int          errors, checked;
  logic        done;

  rv32_core rv32_core_inst (
    .CLK(CLK), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .retire_valid(retire_valid), .retire_wen(retire_wen), .retire_pc(retire_pc),
    .retire_data(retire_data), .retire_rd(retire_rd)
  );

  rv32_checker #(.N(N)) rv32_checker_inst (
    .CLK(CLK), .rst(rst), .retire_valid(retire_valid), .retire_wen(retire_wen),
    .retire_pc(retire_pc), .retire_data(retire_data), .retire_rd(retire_rd),
    .name_tab(name_tab), .must_retire(must_retire), .exp_wen(exp_wen),
    .exp_rd(exp_rd), .exp_data(exp_data), .errors(errors), .checked(checked), .done(done)
  );

  always #5 CLK = ~CLK;
  always @(posedge CLK) cycles <= cycles + 1;

  // memory answers one edge after the address and reads a nop outside the array
  always @(posedge CLK)
    imem_data <= (imem_addr[31:10] == 22'd0) ? imem[imem_addr[9:2]] : `RV_NOP;

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};  // j-type scramble
  endfunction

  task automatic add_test(input logic [79:0] name, input logic [31:0] instr, input logic ret,
                          input logic wen, input logic [4:0] rd, input logic [31:0] data);
    name_tab[n_entries]    = name;
    instr_tab[n_entries]   = instr;
    must_retire[n_entries] = ret;
    exp_wen[n_entries]     = wen;
    exp_rd[n_entries]      = rd;
    exp_data[n_entries]    = data;
    n_entries++;
  endtask

  task automatic build_table;
    // entry i sits at RV_RESET_PC + 4*i with expected values worked out by hand
    add_test("addi_neg",   enc_i(12'hfff, 5'd0, 3'b000, 5'd1, 7'h13), 1, 1, 1, 32'hffffffff);
    add_test("addi_one",   enc_i(12'h001, 5'd0, 3'b000, 5'd2, 7'h13), 1, 1, 2, 32'h00000001);
    add_test("add_carry",  enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1, 1, 3, 32'h00000000);
    add_test("sub_borrow", enc_r(7'h20, 5'd2, 5'd0, 3'b000, 5'd4), 1, 1, 4, 32'hffffffff);
    add_test("slt_neg",    enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd5), 1, 1, 5, 32'h00000001);
    add_test("sltu_neg",   enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd6), 1, 1, 6, 32'h00000000);
    add_test("addi_min",   enc_i(12'h800, 5'd0, 3'b000, 5'd7, 7'h13), 1, 1, 7, 32'hfffff800);
    add_test("sra_neg",    enc_r(7'h20, 5'd2, 5'd7, 3'b101, 5'd8), 1, 1, 8, 32'hfffffc00);
    add_test("srl_neg",    enc_r(7'h00, 5'd2, 5'd7, 3'b101, 5'd9), 1, 1, 9, 32'h7ffffc00);
    add_test("xor",        enc_r(7'h00, 5'd1, 5'd7, 3'b100, 5'd10), 1, 1, 10, 32'h000007ff);
    add_test("or",         enc_r(7'h00, 5'd2, 5'd7, 3'b110, 5'd11), 1, 1, 11, 32'hfffff801);
    add_test("and",        enc_r(7'h00, 5'd1, 5'd7, 3'b111, 5'd12), 1, 1, 12, 32'hfffff800);
    add_test("sll",        enc_r(7'h00, 5'd2, 5'd7, 3'b001, 5'd13), 1, 1, 13, 32'hfffff000);
    add_test("srai",       enc_i(12'h404, 5'd7, 3'b101, 5'd14, 7'h13), 1, 1, 14, 32'hffffff80);
    add_test("srli",       enc_i(12'h01c, 5'd1, 3'b101, 5'd15, 7'h13), 1, 1, 15, 32'h0000000f);
    add_test("slti",       enc_i(12'h000, 5'd1, 3'b010, 5'd16, 7'h13), 1, 1, 16, 32'h00000001);
    add_test("sltiu",      enc_i(12'hfff, 5'd2, 3'b011, 5'd17, 7'h13), 1, 1, 17, 32'h00000001);
    add_test("xori_neg",   enc_i(12'hfff, 5'd2, 3'b100, 5'd18, 7'h13), 1, 1, 18, 32'hfffffffe);
    add_test("slli",       enc_i(12'h01f, 5'd2, 3'b001, 5'd19, 7'h13), 1, 1, 19, 32'h80000000);
    add_test("lui",        {20'h12345, 5'd20, 7'b0110111}, 1, 1, 20, 32'h12345000);
    add_test("auipc",      {20'h00001, 5'd21, 7'b0010111}, 1, 1, 21, 32'h00001150);
    add_test("jal",        enc_jal(21'd8, 5'd22), 1, 1, 22, 32'h00000158);  // lands on 0x15c
    add_test("jal_shadow", enc_i(12'd99, 5'd0, 3'b000, 5'd23, 7'h13), 0, 0, 0, 32'h0);
    add_test("addi_odd",   enc_i(12'h161, 5'd0, 3'b000, 5'd24, 7'h13), 1, 1, 24, 32'h00000161);
    add_test("jalr_odd",   enc_i(12'd8, 5'd24, 3'b000, 5'd25, 7'h67), 1, 1, 25, 32'h00000164);
    add_test("jalr_shdw",  enc_i(12'd77, 5'd0, 3'b000, 5'd23, 7'h13), 0, 0, 0, 32'h0);
    add_test("add_x0",     enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0), 1, 0, 0, 32'h0);
    add_test("read_x0",    enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd26), 1, 1, 26, 32'h00000001);
    add_test("load",       enc_i(12'h000, 5'd0, 3'b010, 5'd27, 7'h03), 1, 0, 0, 32'h0);
    add_test("store",      {7'd0, 5'd1, 5'd0, 3'b010, 5'd0, 7'b0100011}, 1, 0, 0, 32'h0);
    add_test("branch",     32'h00000463, 1, 0, 0, 32'h0);  // beq x0, x0, +8 falls through
    add_test("addi_max",   enc_i(12'h7ff, 5'd26, 3'b000, 5'd28, 7'h13), 1, 1, 28, 32'h00000800);
  endtask

  task automatic load_memory;
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = `RV_NOP;
    end
    for (int i = 0; i < n_entries; i++) begin
      imem[(`RV_RESET_PC >> 2) + i] = instr_tab[i];
    end
  endtask

  initial begin
    rst       = 1'b1;
    imem_data = `RV_NOP;
    build_table();
    load_memory();
    repeat (16) @(posedge CLK);
    rst <= 1'b0;
    while (!done && cycles < TIMEOUT) @(negedge CLK);  // sample away from the edge
    if (!done)
      $display("timeout after %0d cycles, only %0d expected retires seen", cycles, checked);
    $display("%0d tests checked, %0d errors, %0d assertion failures", checked, errors,
             rv32_core_inst.rv32_core_sva_inst.fail_count);
    if (done && errors == 0 && rv32_core_inst.rv32_core_sva_inst.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end
endmodule

/* build.f */
+incdir+source
source/rv32_pkg.sv
source/fetch_stage.sv
source/control_unit.sv
source/reg_file.sv
source/alu.sv
source/execute_stage.sv
source/rv32_core.sv
tests/rv32_core_sva.sv
tests/rv32_checker.sv
tests/rv32_core_tb.sv

/* Bender.yml */
package:
  name: rv32_core

export_include_dirs:
  - source

sources:
  - files:
      - source/rv32_pkg.sv
      - source/fetch_stage.sv
      - source/control_unit.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/execute_stage.sv
      - source/rv32_core.sv
  - target: simulation
    files:
      - tests/rv32_core_sva.sv
      - tests/rv32_checker.sv
      - tests/rv32_core_tb.sv
